// File: sources.f
eth_frame_pkg.sv
rx_ctrl_pkg.sv
rx_byte_tracker.sv
rx_header_capture.sv
icmp_reply_checksum.sv
rx_frame_classifier.sv
rx_frame_parser.sv
tb_rx_frame_parser.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sources.f \
    --top-module tb_rx_frame_parser -o sim_tb \
  && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "Finished with no errors" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

exit 0

// File: tb_rx_frame_parser.sv
`timescale 1ns/10ps

module tb_rx_frame_parser;

  localparam int num_tests  = 9;
  localparam int wait_limit = 400;
  localparam int kind_icmp  = 0;
  localparam int kind_udp   = 1;
  localparam int kind_arp   = 2;
  localparam int kind_other = 3;

  localparam logic [47:0] local_mac   = 48'h02_1a_2b_3c_4d_5e;
  localparam logic [31:0] local_ip    = 32'hc0a8_0a14;
  localparam logic [47:0] other_mac   = 48'h02_00_00_00_00_77;
  localparam logic [31:0] other_ip    = 32'hc0a8_0a63;
  localparam logic [47:0] bcast_mac   = 48'hffff_ffff_ffff;

  logic         rx_ll_clock;
  logic         reset;
  logic [7:0]   rx_ll_data_i;
  logic         rx_ll_sof_n_i;
  logic         rx_ll_eof_n_i;
  logic         rx_ll_src_rdy_n_i;
  logic         arp_reply_i;
  logic         rx_frame_processed_i;
  logic         rx_ll_dst_rdy_n_o;
  logic         arp_req_o;
  logic         udp_frame_o;
  logic         icmp_frame_o;
  logic [95:0]  eth_reply_mac_o;
  logic [63:0]  ip_tx_ip_o;
  logic [223:0] arp_tx_reply_frame_o;
  logic [15:0]  icmp_checksum_o;
  logic [15:0]  ip_frame_len_o;

  // test table filled by load_table
  string       test_name    [num_tests];
  int          test_kind    [num_tests];
  logic [47:0] test_dst_mac [num_tests];
  logic [31:0] test_dst_ip  [num_tests];
  int          test_pay_len [num_tests];
  logic [2:0]  test_flags   [num_tests];
  bit          test_gap     [num_tests];
  int          table_size;

  logic [7:0]  frame_q [$];
  logic [47:0] src_mac;
  logic [31:0] src_ip;
  logic [15:0] exp_frame_len;
  int          test_err;
  int          error_count;
  int          pass_count;
  bit          aborted;

  rx_frame_parser #(
    .cnt_w (16)
  ) i_dut (
    .rx_ll_clock          (rx_ll_clock),
    .reset                (reset),
    .rx_ll_data_i         (rx_ll_data_i),
    .rx_ll_sof_n_i        (rx_ll_sof_n_i),
    .rx_ll_eof_n_i        (rx_ll_eof_n_i),
    .rx_ll_src_rdy_n_i    (rx_ll_src_rdy_n_i),
    .local_mac_i          (local_mac),
    .local_ip_i           (local_ip),
    .arp_reply_i          (arp_reply_i),
    .rx_frame_processed_i (rx_frame_processed_i),
    .rx_ll_dst_rdy_n_o    (rx_ll_dst_rdy_n_o),
    .arp_req_o            (arp_req_o),
    .udp_frame_o          (udp_frame_o),
    .icmp_frame_o         (icmp_frame_o),
    .eth_reply_mac_o      (eth_reply_mac_o),
    .ip_tx_ip_o           (ip_tx_ip_o),
    .arp_tx_reply_frame_o (arp_tx_reply_frame_o),
    .icmp_checksum_o      (icmp_checksum_o),
    .ip_frame_len_o       (ip_frame_len_o)
  );

  initial begin
    rx_ll_clock = 1'b0;
    forever #5 rx_ll_clock = ~rx_ll_clock;
  end

  // ----------------------------------------
  // table and frame builder
  // ----------------------------------------
  task automatic add_entry(input string name, input int kind, input logic [47:0] mac,
                           input logic [31:0] ip, input int pay_len, input logic [2:0] flags,
                           input bit gap);
    test_name[table_size]    = name;
    test_kind[table_size]    = kind;
    test_dst_mac[table_size] = mac;
    test_dst_ip[table_size]  = ip;
    test_pay_len[table_size] = pay_len;
    test_flags[table_size]   = flags;
    test_gap[table_size]     = gap;
    table_size++;
  endtask

  // flags are {arp, udp, icmp}
  task automatic load_table();
    table_size = 0;
    add_entry("icmp_local",     kind_icmp,  local_mac, local_ip, 32, 3'b001, 1'b0);
    add_entry("udp_broadcast",  kind_udp,   bcast_mac, local_ip, 18, 3'b010, 1'b0);
    add_entry("arp_local",      kind_arp,   bcast_mac, local_ip, 18, 3'b100, 1'b0);
    add_entry("drop_wrong_mac", kind_icmp,  other_mac, local_ip, 16, 3'b000, 1'b0);
    add_entry("drop_udp_ip",    kind_udp,   local_mac, other_ip, 10, 3'b000, 1'b0);
    add_entry("drop_arp_ip",    kind_arp,   bcast_mac, other_ip, 18, 3'b000, 1'b0);
    add_entry("drop_ethertype", kind_other, local_mac, local_ip, 20, 3'b000, 1'b0);
    add_entry("icmp_gaps_odd",  kind_icmp,  local_mac, local_ip, 37, 3'b001, 1'b1);
    add_entry("udp_gaps",       kind_udp,   local_mac, local_ip, 25, 3'b010, 1'b1);
  endtask

  // most significant byte first as on the wire
  task automatic push_bytes(input logic [47:0] value, input int count);
    int n;
    for (n = count - 1; n >= 0; n--) begin
      frame_q.push_back(value[n*8 +: 8]);
    end
  endtask

  task automatic push_random(input int count);
    int n;
    for (n = 0; n < count; n++) begin
      frame_q.push_back(8'($urandom));
    end
  endtask

  task automatic build_frame(input int idx);
    logic [15:0] ip_len;
    int          kind;
    int          pay;
    kind = test_kind[idx];
    pay  = test_pay_len[idx];
    frame_q.delete();
    src_mac = {16'h0a00, 32'($urandom)};
    src_ip  = {16'hc0a8, 16'($urandom)};
    push_bytes(test_dst_mac[idx], 6);
    push_bytes(src_mac, 6);
    if (kind == kind_icmp || kind == kind_udp) begin
      ip_len = (kind == kind_icmp) ? 16'(24 + pay) : 16'(28 + pay);
      exp_frame_len = ip_len + 16'd14;
      push_bytes(48'h0800_4500, 4);
      push_bytes(48'(ip_len), 2);
      push_bytes(48'($urandom), 2);
      push_bytes(48'h4000_40, 3);
      push_bytes((kind == kind_icmp) ? 48'h01 : 48'h11, 1);
      push_bytes(48'h0000, 2);
      push_bytes(48'(src_ip), 4);
      push_bytes(48'(test_dst_ip[idx]), 4);
      if (kind == kind_icmp) begin
        // echo request with a zero checksum field
        push_bytes(48'h0800_0000, 4);
      end else begin
        push_bytes(48'($urandom), 4);
        push_bytes(48'(8 + pay), 2);
        push_bytes(48'h0000, 2);
      end
      push_random(pay);
    end else if (kind == kind_arp) begin
      push_bytes(48'h0806, 2);
      push_bytes(48'h0001_0800_0604, 6);
      push_bytes(48'h0001, 2);
      push_bytes(src_mac, 6);
      push_bytes(48'(src_ip), 4);
      push_bytes(48'h0, 6);
      push_bytes(48'(test_dst_ip[idx]), 4);
      // pad up to the ethernet minimum
      push_bytes(48'h0, pay);
    end else begin
      push_bytes(48'h86dd, 2);
      push_random(40 + pay);
    end
  endtask

  // reply header words are all zero so only bytes 38 on count
  function automatic logic [15:0] reply_checksum();
    logic [31:0] acc;
    int          i;
    acc = 32'd0;
    for (i = 38; i < frame_q.size(); i += 2) begin
      if (i + 1 < frame_q.size()) begin
        acc = acc + 32'({frame_q[i], frame_q[i+1]});
      end else begin
        acc = acc + 32'({frame_q[i], 8'h00});
      end
    end
    while (acc[31:16] != 16'd0) begin
      acc = 32'(acc[15:0]) + 32'(acc[31:16]);
    end
    return ~acc[15:0];
  endfunction

  // ----------------------------------------
  // stimulus and waits
  // ----------------------------------------
  task automatic send_frame(input bit gap);
    int i;
    int last;
    last = frame_q.size() - 1;
    for (i = 0; i <= last; i++) begin
      if (gap && i > 0 && ($urandom % 4) == 0) begin
        repeat (1 + $urandom % 3) begin
          @(posedge rx_ll_clock);
          rx_ll_src_rdy_n_i <= 1'b1;
          rx_ll_sof_n_i     <= 1'b1;
          rx_ll_eof_n_i     <= 1'b1;
        end
      end
      @(posedge rx_ll_clock);
      rx_ll_data_i      <= frame_q[i];
      rx_ll_sof_n_i     <= (i == 0) ? 1'b0 : 1'b1;
      rx_ll_eof_n_i     <= (i == last) ? 1'b0 : 1'b1;
      rx_ll_src_rdy_n_i <= 1'b0;
    end
    @(posedge rx_ll_clock);
    rx_ll_sof_n_i     <= 1'b1;
    rx_ll_eof_n_i     <= 1'b1;
    rx_ll_src_rdy_n_i <= 1'b1;
  endtask

  // sel 0 reads rx_ll_dst_rdy_n_o and sel 1 reads arp_req_o
  function automatic logic status_level(input int sel);
    if (sel == 0) begin
      return rx_ll_dst_rdy_n_o;
    end
    return arp_req_o;
  endfunction

  task automatic wait_until(input int sel, input logic level, input string what,
                            output bit ok);
    int n;
    ok = 1'b0;
    for (n = 0; n < wait_limit; n++) begin
      @(negedge rx_ll_clock);
      if (status_level(sel) == level) begin
        ok = 1'b1;
        break;
      end
    end
    if (!ok) begin
      $display("timeout after %0d cycles waiting for %s", wait_limit, what);
    end
  endtask

  task automatic pulse_input(input int sel);
    @(posedge rx_ll_clock);
    if (sel == 0) begin
      rx_frame_processed_i <= 1'b1;
    end else begin
      arp_reply_i <= 1'b1;
    end
    @(posedge rx_ll_clock);
    rx_frame_processed_i <= 1'b0;
    arp_reply_i          <= 1'b0;
  endtask

  // ----------------------------------------
  // one table entry
  // ----------------------------------------
  task automatic run_test(input int idx);
    bit            ok;
    bit            raised;
    int            n;
    logic [2:0]    flags;
    logic [15:0]   exp_sum;
    logic [223:0]  exp_arp;
    test_err = 0;
    build_frame(idx);
    exp_sum = reply_checksum();
    exp_arp = {16'h0001, 16'h0800, 16'h0604, 16'h0002, local_mac, local_ip, src_mac, src_ip};
    send_frame(test_gap[idx]);
    if (test_flags[idx] == 3'b000) begin
      raised = 1'b0;
      for (n = 0; n < 30; n++) begin
        @(negedge rx_ll_clock);
        if ({arp_req_o, udp_frame_o, icmp_frame_o} != 3'b000 || rx_ll_dst_rdy_n_o) begin
          raised = 1'b1;
        end
      end
      if (raised) begin
        $display("test %s: a flag or ready went high for a frame that must be dropped",
                 test_name[idx]);
        test_err++;
      end
    end else if (test_flags[idx] == 3'b100) begin
      wait_until(1, 1'b1, "arp_req_o to rise", ok);
      if (!ok) begin
        aborted = 1'b1;
        test_err++;
        return;
      end
      flags = {arp_req_o, udp_frame_o, icmp_frame_o};
      if (flags != test_flags[idx]) begin
        $display("FAILED %s: flags expected %b actual %b", test_name[idx], test_flags[idx], flags);
        test_err++;
      end
      if (arp_tx_reply_frame_o != exp_arp) begin
        $display("FAILED %s: arp_tx_reply_frame_o expected %h actual %h", test_name[idx],
                 exp_arp, arp_tx_reply_frame_o);
        test_err++;
      end
      // request holds until the reply is sent
      raised = 1'b0;
      for (n = 0; n < 8; n++) begin
        @(negedge rx_ll_clock);
        if (!arp_req_o) raised = 1'b1;
      end
      if (raised) begin
        $display("test %s: arp_req_o dropped before arp_reply_i", test_name[idx]);
        test_err++;
      end
      pulse_input(1);
      wait_until(1, 1'b0, "arp_req_o to clear", ok);
      if (!ok) begin
        aborted = 1'b1;
        test_err++;
        return;
      end
    end else begin
      wait_until(0, 1'b1, "rx_ll_dst_rdy_n_o to rise", ok);
      if (!ok) begin
        aborted = 1'b1;
        test_err++;
        return;
      end
      flags = {arp_req_o, udp_frame_o, icmp_frame_o};
      if (flags != test_flags[idx]) begin
        $display("FAILED %s: flags expected %b actual %b", test_name[idx], test_flags[idx], flags);
        test_err++;
      end
      if (ip_frame_len_o != exp_frame_len) begin
        $display("FAILED %s: ip_frame_len_o expected %h actual %h", test_name[idx],
                 exp_frame_len, ip_frame_len_o);
        test_err++;
      end
      if (eth_reply_mac_o != {src_mac, local_mac}) begin
        $display("FAILED %s: eth_reply_mac_o expected %h actual %h", test_name[idx],
                 {src_mac, local_mac}, eth_reply_mac_o);
        test_err++;
      end
      if (ip_tx_ip_o != {local_ip, src_ip}) begin
        $display("FAILED %s: ip_tx_ip_o expected %h actual %h", test_name[idx],
                 {local_ip, src_ip}, ip_tx_ip_o);
        test_err++;
      end
      if (test_flags[idx] == 3'b001 && icmp_checksum_o != exp_sum) begin
        $display("FAILED %s: icmp_checksum_o expected %h actual %h", test_name[idx],
                 exp_sum, icmp_checksum_o);
        test_err++;
      end
      pulse_input(0);
      wait_until(0, 1'b0, "rx_ll_dst_rdy_n_o to clear", ok);
      if (!ok) begin
        aborted = 1'b1;
        test_err++;
        return;
      end
      flags = {arp_req_o, udp_frame_o, icmp_frame_o};
      if (flags != 3'b000) begin
        $display("FAILED %s: flags after processing expected %b actual %b", test_name[idx],
                 3'b000, flags);
        test_err++;
      end
    end
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin : main_flow
    int t;
    void'($urandom(28976));
    reset                = 1'b1;
    rx_ll_data_i         = 8'h00;
    rx_ll_sof_n_i        = 1'b1;
    rx_ll_eof_n_i        = 1'b1;
    rx_ll_src_rdy_n_i    = 1'b1;
    arp_reply_i          = 1'b0;
    rx_frame_processed_i = 1'b0;
    error_count          = 0;
    pass_count           = 0;
    aborted              = 1'b0;
    load_table();
    repeat (4) @(posedge rx_ll_clock);
    reset <= 1'b0;
    repeat (2) @(posedge rx_ll_clock);
    for (t = 0; t < table_size; t++) begin
      run_test(t);
      if (test_err == 0) begin
        pass_count++;
        $display("test %s passed", test_name[t]);
      end else begin
        $display("test %s failed with %0d errors", test_name[t], test_err);
      end
      error_count += test_err;
      if (aborted) break;
    end
    $display("tests run %0d, passed %0d, errors %0d", t + (aborted ? 1 : 0), pass_count,
             error_count);
    if (error_count == 0 && !aborted) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: rx_frame_parser.sv
`timescale 1ns/10ps

module rx_frame_parser #(
  parameter int cnt_w = 16
) (
  input  logic         rx_ll_clock,
  input  logic         reset,
  input  logic [7:0]   rx_ll_data_i,
  input  logic         rx_ll_sof_n_i,
  input  logic         rx_ll_eof_n_i,
  input  logic         rx_ll_src_rdy_n_i,
  input  logic [47:0]  local_mac_i,
  input  logic [31:0]  local_ip_i,
  input  logic         arp_reply_i,
  input  logic         rx_frame_processed_i,
  output logic         rx_ll_dst_rdy_n_o,
  output logic         arp_req_o,
  output logic         udp_frame_o,
  output logic         icmp_frame_o,
  output logic [95:0]  eth_reply_mac_o,
  output logic [63:0]  ip_tx_ip_o,
  output logic [223:0] arp_tx_reply_frame_o,
  output logic [15:0]  icmp_checksum_o,
  output logic [15:0]  ip_frame_len_o
);

  import eth_frame_pkg::*;

  logic [cnt_w-1:0] byte_cnt;
  logic [47:0]      byte_win;
  logic             new_byte;

  logic [47:0] dst_mac;
  logic [47:0] src_mac;
  logic [15:0] eth_type;
  logic [7:0]  ip_proto;
  logic [31:0] src_ip;
  logic [31:0] dst_ip;
  logic [15:0] icmp_type;
  logic [15:0] arp_op;
  logic [47:0] arp_sender_mac;
  logic [31:0] arp_sender_ip;
  logic [31:0] arp_target_ip;

  rx_byte_tracker #(
    .cnt_w (cnt_w)
  ) i_tracker (
    .rx_ll_clock       (rx_ll_clock),
    .reset             (reset),
    .rx_ll_data_i      (rx_ll_data_i),
    .rx_ll_sof_n_i     (rx_ll_sof_n_i),
    .rx_ll_eof_n_i     (rx_ll_eof_n_i),
    .rx_ll_src_rdy_n_i (rx_ll_src_rdy_n_i),
    .byte_cnt_o        (byte_cnt),
    .byte_win_o        (byte_win),
    .new_byte_o        (new_byte)
  );

  rx_header_capture #(
    .cnt_w (cnt_w)
  ) i_capture (
    .rx_ll_clock      (rx_ll_clock),
    .byte_cnt_i       (byte_cnt),
    .byte_win_i       (byte_win),
    .dst_mac_o        (dst_mac),
    .src_mac_o        (src_mac),
    .eth_type_o       (eth_type),
    .ip_frame_len_o   (ip_frame_len_o),
    .ip_proto_o       (ip_proto),
    .src_ip_o         (src_ip),
    .dst_ip_o         (dst_ip),
    .icmp_type_o      (icmp_type),
    .arp_op_o         (arp_op),
    .arp_sender_mac_o (arp_sender_mac),
    .arp_sender_ip_o  (arp_sender_ip),
    .arp_target_ip_o  (arp_target_ip)
  );

  rx_frame_classifier #(
    .cnt_w (cnt_w)
  ) i_classifier (
    .rx_ll_clock          (rx_ll_clock),
    .reset                (reset),
    .rx_ll_sof_n_i        (rx_ll_sof_n_i),
    .rx_ll_eof_n_i        (rx_ll_eof_n_i),
    .byte_cnt_i           (byte_cnt),
    .dst_mac_i            (dst_mac),
    .eth_type_i           (eth_type),
    .arp_op_i             (arp_op),
    .ip_proto_i           (ip_proto),
    .dst_ip_i             (dst_ip),
    .icmp_type_i          (icmp_type),
    .arp_target_ip_i      (arp_target_ip),
    .local_mac_i          (local_mac_i),
    .local_ip_i           (local_ip_i),
    .arp_reply_i          (arp_reply_i),
    .rx_frame_processed_i (rx_frame_processed_i),
    .arp_req_o            (arp_req_o),
    .udp_frame_o          (udp_frame_o),
    .icmp_frame_o         (icmp_frame_o),
    .rx_ll_dst_rdy_n_o    (rx_ll_dst_rdy_n_o)
  );

  icmp_reply_checksum #(
    .cnt_w (cnt_w)
  ) i_checksum (
    .rx_ll_clock  (rx_ll_clock),
    .reset        (reset),
    .byte_cnt_i   (byte_cnt),
    .byte_win_i   (byte_win),
    .new_byte_i   (new_byte),
    .icmp_frame_i (icmp_frame_o),
    .checksum_o   (icmp_checksum_o)
  );

  // ----------------------------------------
  // reply address pairs and arp body
  // ----------------------------------------
  assign eth_reply_mac_o = {src_mac, local_mac_i};
  assign ip_tx_ip_o      = {local_ip_i, src_ip};

  // local side becomes the sender, the requester the target
  assign arp_tx_reply_frame_o = {arp_hw_type, arp_proto_type, arp_len_code, arp_op_reply,
                                 local_mac_i, local_ip_i, arp_sender_mac, arp_sender_ip};

endmodule

// File: rx_frame_classifier.sv
`timescale 1ns/10ps

module rx_frame_classifier #(
  parameter int cnt_w = 16
) (
  input  logic             rx_ll_clock,
  input  logic             reset,
  input  logic             rx_ll_sof_n_i,
  input  logic             rx_ll_eof_n_i,
  input  logic [cnt_w-1:0] byte_cnt_i,
  input  logic [47:0]      dst_mac_i,
  input  logic [15:0]      eth_type_i,
  input  logic [15:0]      arp_op_i,
  input  logic [7:0]       ip_proto_i,
  input  logic [31:0]      dst_ip_i,
  input  logic [15:0]      icmp_type_i,
  input  logic [31:0]      arp_target_ip_i,
  input  logic [47:0]      local_mac_i,
  input  logic [31:0]      local_ip_i,
  input  logic             arp_reply_i,
  input  logic             rx_frame_processed_i,
  output logic             arp_req_o,
  output logic             udp_frame_o,
  output logic             icmp_frame_o,
  output logic             rx_ll_dst_rdy_n_o
);

  import eth_frame_pkg::*;
  import rx_ctrl_pkg::*;

  eth_state_e eth_state;
  logic       mac_match;
  logic       ip_to_local;
  logic       is_icmp_echo;
  logic       is_udp;
  logic       is_arp_req;
  logic       arp_for_local;

  // ----------------------------------------
  // field checks
  // ----------------------------------------
  assign mac_match     = (dst_mac_i == broadcast_mac) || (dst_mac_i == local_mac_i);
  assign ip_to_local   = (dst_ip_i == local_ip_i);
  assign is_icmp_echo  = (ip_proto_i == ip_proto_icmp) && ip_to_local &&
                         (icmp_type_i == icmp_echo_request);
  assign is_udp        = (ip_proto_i == ip_proto_udp) && ip_to_local;
  assign is_arp_req    = (eth_type_i == eth_type_arp) && (arp_op_i == arp_op_request);
  assign arp_for_local = (arp_target_ip_i == local_ip_i);

  // ----------------------------------------
  // control fsm
  // ----------------------------------------
  always_ff @(posedge rx_ll_clock) begin
    if (reset) begin
      eth_state         <= es_wait;
      arp_req_o         <= 1'b0;
      udp_frame_o       <= 1'b0;
      icmp_frame_o      <= 1'b0;
      rx_ll_dst_rdy_n_o <= 1'b0;
    end else begin
      case (eth_state)
        es_wait: begin
          if (!rx_ll_sof_n_i) begin
            eth_state <= es_mac;
          end
        end
        // dst mac is loaded by the time the count reads 7
        es_mac: begin
          if (byte_cnt_i == cnt_w'(pos_dst_mac + 1)) begin
            eth_state <= mac_match ? es_eth_type : es_drop;
          end
        end
        es_eth_type: begin
          if (byte_cnt_i == cnt_w'(pos_eth_decide)) begin
            if (eth_type_i == eth_type_ip) begin
              eth_state <= es_ip;
            end else if (is_arp_req) begin
              eth_state <= es_arp_req;
            end else begin
              eth_state <= es_drop;
            end
          end
        end
        es_arp_req: begin
          if (!rx_ll_eof_n_i) begin
            eth_state <= es_arp_chk;
          end
        end
        es_arp_chk: begin
          if (arp_for_local) begin
            arp_req_o <= 1'b1;
            eth_state <= es_arp_rly;
          end else begin
            eth_state <= es_wait;
          end
        end
        es_arp_rly: begin
          if (arp_reply_i) begin
            arp_req_o <= 1'b0;
            eth_state <= es_wait;
          end
        end
        es_ip: begin
          if (byte_cnt_i == cnt_w'(pos_ip_decide)) begin
            if (is_icmp_echo) begin
              icmp_frame_o <= 1'b1;
              eth_state    <= es_icmp;
            end else if (is_udp) begin
              udp_frame_o <= 1'b1;
              eth_state   <= es_udp;
            end else begin
              eth_state <= es_drop;
            end
          end
        end
        es_icmp, es_udp, es_drop: begin
          if (!rx_ll_eof_n_i) begin
            eth_state <= es_eof;
          end
        end
        es_eof: begin
          // only accepted frames hold off the source
          if (rx_ll_eof_n_i) begin
            if (icmp_frame_o || udp_frame_o) begin
              rx_ll_dst_rdy_n_o <= 1'b1;
              eth_state         <= es_frame_pro;
            end else begin
              eth_state <= es_wait;
            end
          end
        end
        es_frame_pro: begin
          if (rx_frame_processed_i) begin
            icmp_frame_o      <= 1'b0;
            udp_frame_o       <= 1'b0;
            rx_ll_dst_rdy_n_o <= 1'b0;
            eth_state         <= es_wait;
          end
        end
        default: eth_state <= es_wait;
      endcase
    end
  end

endmodule

// File: icmp_reply_checksum.sv
`timescale 1ns/10ps

module icmp_reply_checksum #(
  parameter int cnt_w = 16
) (
  input  logic             rx_ll_clock,
  input  logic             reset,
  input  logic [cnt_w-1:0] byte_cnt_i,
  input  logic [47:0]      byte_win_i,
  input  logic             new_byte_i,
  input  logic             icmp_frame_i,
  output logic [15:0]      checksum_o
);

  import eth_frame_pkg::*;
  import rx_ctrl_pkg::*;

  chk_state_e  chk_state;
  logic        feed_vld;
  logic [7:0]  feed_byte;
  logic        low_half;
  logic [15:0] sum;
  logic [15:0] addend;
  logic [16:0] sum_ext;

  // ----------------------------------------
  // byte source per state
  // ----------------------------------------
  always_comb begin
    feed_vld  = 1'b0;
    feed_byte = 8'h00;
    case (chk_state)
      cs_type_h: begin
        feed_vld  = 1'b1;
        feed_byte = icmp_echo_reply[15:8];
      end
      cs_type_l: begin
        feed_vld  = 1'b1;
        feed_byte = icmp_echo_reply[7:0];
      end
      // checksum field counts as zero
      cs_sum_h, cs_sum_l: feed_vld = 1'b1;
      cs_payload: begin
        feed_vld  = new_byte_i & icmp_frame_i & (byte_cnt_i != cnt_w'(1));
        feed_byte = byte_win_i[7:0];
      end
      default: ;
    endcase
  end

  // ----------------------------------------
  // sequencer
  // ----------------------------------------
  always_ff @(posedge rx_ll_clock) begin
    if (reset) begin
      chk_state <= cs_wait;
    end else begin
      case (chk_state)
        cs_wait: begin
          if (byte_cnt_i == cnt_w'(pos_ip_proto)) begin
            chk_state <= cs_reset_a;
          end
        end
        cs_reset_a: chk_state <= cs_reset_r;
        cs_reset_r: chk_state <= cs_type_h;
        cs_type_h:  chk_state <= cs_type_l;
        cs_type_l:  chk_state <= cs_sum_h;
        cs_sum_h:   chk_state <= cs_sum_l;
        cs_sum_l:   chk_state <= cs_hold;
        cs_hold: begin
          if (byte_cnt_i == cnt_w'(1)) begin
            chk_state <= cs_wait;
          end else if (byte_cnt_i == cnt_w'(pos_icmp_payload)) begin
            chk_state <= cs_payload;
          end
        end
        cs_payload: begin
          // runs until the next frame starts
          if (byte_cnt_i == cnt_w'(1)) begin
            chk_state <= cs_wait;
          end
        end
        default: chk_state <= cs_wait;
      endcase
    end
  end

  // even bytes are the high half of a word
  assign addend  = low_half ? {8'h00, feed_byte} : {feed_byte, 8'h00};
  assign sum_ext = {1'b0, sum} + {1'b0, addend};

  always_ff @(posedge rx_ll_clock) begin
    if (reset || (chk_state == cs_reset_a)) begin
      sum      <= '0;
      low_half <= 1'b0;
    end else if (feed_vld) begin
      // end-around carry
      sum      <= sum_ext[15:0] + {15'd0, sum_ext[16]};
      low_half <= ~low_half;
    end
  end

  assign checksum_o = ~sum;

endmodule

// File: rx_header_capture.sv
`timescale 1ns/10ps

module rx_header_capture #(
  parameter int cnt_w = 16
) (
  input  logic             rx_ll_clock,
  input  logic [cnt_w-1:0] byte_cnt_i,
  input  logic [47:0]      byte_win_i,
  output logic [47:0]      dst_mac_o,
  output logic [47:0]      src_mac_o,
  output logic [15:0]      eth_type_o,
  output logic [15:0]      ip_frame_len_o,
  output logic [7:0]       ip_proto_o,
  output logic [31:0]      src_ip_o,
  output logic [31:0]      dst_ip_o,
  output logic [15:0]      icmp_type_o,
  output logic [15:0]      arp_op_o,
  output logic [47:0]      arp_sender_mac_o,
  output logic [31:0]      arp_sender_ip_o,
  output logic [31:0]      arp_target_ip_o
);

  import eth_frame_pkg::*;

  // ----------------------------------------
  // ethernet header
  // ----------------------------------------
  always_ff @(posedge rx_ll_clock) begin
    case (byte_cnt_i)
      cnt_w'(pos_dst_mac):  dst_mac_o  <= byte_win_i;
      cnt_w'(pos_src_mac):  src_mac_o  <= byte_win_i;
      cnt_w'(pos_eth_type): eth_type_o <= byte_win_i[15:0];
      default: ;
    endcase
  end

  // ----------------------------------------
  // ip and icmp header
  // ----------------------------------------
  always_ff @(posedge rx_ll_clock) begin
    case (byte_cnt_i)
      // total length plus the mac header gives the full frame
      cnt_w'(pos_ip_len): begin
        ip_frame_len_o <= eth_hdr_len + byte_win_i[15:0];
      end
      cnt_w'(pos_ip_proto):  ip_proto_o  <= byte_win_i[7:0];
      cnt_w'(pos_src_ip):    src_ip_o    <= byte_win_i[31:0];
      cnt_w'(pos_dst_ip):    dst_ip_o    <= byte_win_i[31:0];
      cnt_w'(pos_icmp_type): icmp_type_o <= byte_win_i[15:0];
      default: ;
    endcase
  end

  // ----------------------------------------
  // arp body
  // ----------------------------------------
  // these overlap the ip positions, only one set is meaningful per frame
  always_ff @(posedge rx_ll_clock) begin
    case (byte_cnt_i)
      cnt_w'(pos_arp_op):         arp_op_o         <= byte_win_i[15:0];
      cnt_w'(pos_arp_sender_mac): arp_sender_mac_o <= byte_win_i;
      cnt_w'(pos_arp_sender_ip):  arp_sender_ip_o  <= byte_win_i[31:0];
      cnt_w'(pos_arp_target_ip):  arp_target_ip_o  <= byte_win_i[31:0];
      default: ;
    endcase
  end

endmodule

// File: rx_byte_tracker.sv
`timescale 1ns/10ps

module rx_byte_tracker #(
  parameter int cnt_w = 16
) (
  input  logic             rx_ll_clock,
  input  logic             reset,
  input  logic [7:0]       rx_ll_data_i,
  input  logic             rx_ll_sof_n_i,
  input  logic             rx_ll_eof_n_i,
  input  logic             rx_ll_src_rdy_n_i,
  output logic [cnt_w-1:0] byte_cnt_o,
  output logic [47:0]      byte_win_o,
  output logic             new_byte_o
);

  import rx_ctrl_pkg::*;

  ll_state_e ll_state;
  logic      accept;

  // first byte goes with sof, the rest need src_rdy
  always_comb begin
    case (ll_state)
      ll_wait:         accept = ~rx_ll_sof_n_i;
      ll_sof, ll_data: accept = ~rx_ll_src_rdy_n_i;
      default:         accept = 1'b0;
    endcase
  end

  // ----------------------------------------
  // framing fsm and byte counter
  // ----------------------------------------
  always_ff @(posedge rx_ll_clock) begin
    if (reset) begin
      ll_state   <= ll_wait;
      byte_cnt_o <= '0;
      new_byte_o <= 1'b0;
    end else begin
      new_byte_o <= accept;
      case (ll_state)
        ll_wait: begin
          if (accept) begin
            byte_cnt_o <= cnt_w'(1);
            ll_state   <= ll_sof;
          end
        end
        ll_sof, ll_data: begin
          if (accept) begin
            byte_cnt_o <= byte_cnt_o + cnt_w'(1);
            ll_state   <= rx_ll_eof_n_i ? ll_data : ll_eof;
          end
        end
        ll_eof: begin
          // wait for eof_n to drop back before the next sof
          if (rx_ll_eof_n_i) begin
            ll_state <= ll_wait;
          end
        end
        default: ll_state <= ll_wait;
      endcase
    end
  end

  // newest byte in the low end
  always_ff @(posedge rx_ll_clock) begin
    if (accept) begin
      byte_win_o <= {byte_win_o[39:0], rx_ll_data_i};
    end
  end

endmodule

// File: rx_ctrl_pkg.sv
package rx_ctrl_pkg;

  // locallink framing
  typedef enum logic [1:0] {
    ll_wait,
    ll_sof,
    ll_data,
    ll_eof
  } ll_state_e;

  // frame classifier
  typedef enum logic [3:0] {
    es_wait,
    es_mac,
    es_eth_type,
    es_arp_req,
    es_arp_chk,
    es_arp_rly,
    es_ip,
    es_icmp,
    es_udp,
    es_drop,
    es_eof,
    es_frame_pro
  } eth_state_e;

  // icmp reply checksum sequencer
  typedef enum logic [3:0] {
    cs_wait,
    cs_reset_a,
    cs_reset_r,
    cs_type_h,
    cs_type_l,
    cs_sum_h,
    cs_sum_l,
    cs_hold,
    cs_payload
  } chk_state_e;

endpackage

// File: eth_frame_pkg.sv
package eth_frame_pkg;

  // ----------------------------------------
  // ethernet and ip protocol codes
  // ----------------------------------------
  localparam logic [15:0] eth_type_arp = 16'h0806;
  localparam logic [15:0] eth_type_ip  = 16'h0800;

  localparam logic [15:0] arp_op_request = 16'h0001;

  localparam logic [7:0] ip_proto_icmp = 8'h01;
  localparam logic [7:0] ip_proto_udp  = 8'h11;

  // icmp type and code as one word
  localparam logic [15:0] icmp_echo_request = 16'h0800;
  localparam logic [15:0] icmp_echo_reply   = 16'h0000;

  localparam logic [47:0] broadcast_mac = 48'hffff_ffff_ffff;

  // leading words of the arp reply body
  localparam logic [15:0] arp_hw_type    = 16'h0001;
  localparam logic [15:0] arp_proto_type = 16'h0800;
  localparam logic [15:0] arp_len_code   = 16'h0604;
  localparam logic [15:0] arp_op_reply   = 16'h0002;

  // mac header bytes in front of the ip datagram
  localparam logic [15:0] eth_hdr_len = 16'd14;

  // ----------------------------------------
  // byte counts at which a field is complete
  // ----------------------------------------
  localparam int unsigned pos_dst_mac        = 6;
  localparam int unsigned pos_src_mac        = 12;
  localparam int unsigned pos_eth_type       = 14;
  localparam int unsigned pos_ip_len         = 18;
  localparam int unsigned pos_arp_op         = 22;
  localparam int unsigned pos_eth_decide     = 23;
  localparam int unsigned pos_ip_proto       = 24;
  localparam int unsigned pos_arp_sender_mac = 28;
  localparam int unsigned pos_src_ip         = 30;
  localparam int unsigned pos_arp_sender_ip  = 32;
  localparam int unsigned pos_dst_ip         = 34;
  localparam int unsigned pos_icmp_type      = 36;
  localparam int unsigned pos_ip_decide      = 37;
  localparam int unsigned pos_icmp_payload   = 38;
  localparam int unsigned pos_arp_target_ip  = 42;

endpackage
